// ==== project.f ====
cache_bus_pkg.sv
cache_geom_pkg.sv
icache_array_if.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
tb_icache_sva.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_icache
OBJ_DIR ?= obj_dir
FILE_LIST ?= project.f
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= PASS: all tests

SOURCES := $(filter %.sv %.v,$(shell cat $(FILE_LIST)))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_icache.sv ====
`default_nettype none

module tb_icache;

	localparam int tb_cache_bytes = 512;
	localparam int tb_line_bytes = 16;
	localparam logic [31:0] data_key = 32'h5a3c_96e1; // same key as the assertion module.
	localparam logic [29:0] err_word = 30'h128;
	localparam logic [31:0] seed = 32'h914c8652;
	localparam int ack_timeout = 200;

	logic clk = 1'b0;
	logic rst;
	logic c_access;
	logic [29:0] c_addr;
	logic [31:0] c_data;
	logic c_ack;
	logic c_error;
	logic ctrl_inval;
	logic m_access;
	logic [29:0] m_addr;
	logic [31:0] m_data;
	logic m_ack;
	logic m_error;
	int errors = 0;

	icache_top #(.cache_bytes(tb_cache_bytes), .line_bytes(tb_line_bytes)) UUT (
		.clk(clk), .rst(rst),
		.c_access(c_access), .c_addr(c_addr), .c_data(c_data),
		.c_ack(c_ack), .c_error(c_error), .ctrl_inval(ctrl_inval),
		.m_access(m_access), .m_addr(m_addr), .m_data(m_data),
		.m_ack(m_ack), .m_error(m_error)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic is_err_line(input logic [29:0] a);
		return a[29:2] == err_word[29:2]; // 16-byte lines, four words each.
	endfunction

	// memory answers each word after 0 to 3 cycles.
	initial begin : memory_model
		logic [31:0] lfsr;
		logic [1:0] wait_left;
		logic busy;
		int b;
		m_ack = 1'b0;
		m_error = 1'b0;
		m_data = '0;
		lfsr = seed;
		busy = 1'b0;
		wait_left = '0;
		forever begin
			@(posedge clk);
			#2;
			m_ack = 1'b0;
			m_error = 1'b0;
			if (!m_access) begin
				busy = 1'b0;
			end else begin
				if (!busy) begin
					for (b = 0; b < 2; b++) begin
						lfsr = lfsr_next(lfsr);
						wait_left = {wait_left[0], lfsr[0]};
					end
					busy = 1'b1;
				end
				if (wait_left == 0) begin
					busy = 1'b0;
					if (is_err_line(m_addr)) begin
						m_error = 1'b1;
					end else begin
						m_ack = 1'b1;
						m_data = {2'b00, m_addr} ^ data_key;
					end
				end else begin
					wait_left = wait_left - 1'b1;
				end
			end
		end
	end

	task automatic fetch(input logic [29:0] addr);
		int cycles;
		logic got;
		c_access = 1'b1;
		c_addr = addr;
		cycles = 0;
		got = 1'b0;
		while (!got && cycles < ack_timeout) begin
			@(negedge clk);
			if (c_ack)
				got = 1'b1;
			else
				cycles++;
		end
		if (!got) begin
			errors++;
			$display("timeout: no c_ack within %0d cycles for address %h", ack_timeout, addr);
		end else begin
			assert (c_error === is_err_line(addr))
			else begin
				errors++;
				$display("Error at %0t: c_error = %b, expected %b", $time, c_error,
					is_err_line(addr));
			end
		end
		@(posedge clk);
		#2;
		c_access = 1'b0;
	endtask

	initial begin
		int i;
		int w;
		int assert_fails;
		logic [29:0] a;
		rst = 1'b1;
		c_access = 1'b0;
		c_addr = '0;
		ctrl_inval = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		repeat (3) @(posedge clk); // quiet time before the first request.
		#2;
		for (i = 0; i < 6; i++)
			for (w = 0; w < 4; w++)
				fetch(30'(32'h100 + i * 4 + w));
		for (i = 0; i < 4; i++) begin
			a = 30'(32'h100 + i * 5);
			fetch(a);
			fetch(a);
		end
		fetch(30'h184); // same index as 0x104, other tag.
		fetch(30'h104);
		fetch(30'h104);
		ctrl_inval = 1'b1;
		@(posedge clk);
		#2;
		ctrl_inval = 1'b0;
		fetch(30'h100);
		fetch(30'h100);
		fetch(err_word + 30'd1);
		fetch(err_word + 30'd2);
		fetch(30'h101);
		for (i = 0; i < 40; i++) begin
			a = 30'(32'h100 + (i * 37) % 64);
			if (i % 8 == 3)
				a = a ^ 30'h80;
			fetch(a);
		end
		repeat (5) @(posedge clk);
		assert_fails = UUT.chk.fail_count;
		$display("errors: %0d testbench, %0d assertion", errors, assert_fails);
		if (errors + assert_fails == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_icache_sva.sv ====
`default_nettype none

module tb_icache_sva #(
	parameter int cache_bytes = cache_geom_pkg::default_cache_bytes,
	parameter int line_bytes = cache_geom_pkg::default_line_bytes,
	parameter logic [31:0] data_key = 32'h5a3c_96e1,
	parameter logic [29:0] err_word = 30'h128
) (
	input wire clk,
	input wire rst,
	input wire c_access,
	input wire [29:0] c_addr,
	input wire [31:0] c_data,
	input wire c_ack,
	input wire c_error,
	input wire ctrl_inval,
	input wire m_access,
	input wire [29:0] m_addr,
	input wire m_ack,
	input wire m_error,
	input cache_bus_pkg::ctrl_state_t state
);

	localparam int ob = cache_geom_pkg::offset_bits(line_bytes);

	int fail_count = 0;
	logic cached; // last acknowledged word is still known to be in the cache.
	logic [29:0] last_addr;
	logic inval_seen;
	logic seen_access;
	logic [ob-1:0] offs;
	logic [ob-1:0] exp_offs;
	logic fetch_start;
	logic [2:0] err_pipe;
	logic [2:0] inval_pipe;

	function automatic logic [31:0] mem_word(input logic [29:0] a);
		return {2'b00, a} ^ data_key;
	endfunction

	assign offs = m_addr[ob-1:0];
	assign fetch_start = state == cache_bus_pkg::state_idle && c_access && !c_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			cached <= 1'b0;
			inval_seen <= 1'b0;
			seen_access <= 1'b0;
			err_pipe <= '0;
			inval_pipe <= '0;
		end else begin
			if (ctrl_inval || m_access)
				cached <= 1'b0;
			else if (c_ack && !c_error)
				cached <= 1'b1;
			if (ctrl_inval)
				inval_seen <= 1'b1;
			else if (m_access)
				inval_seen <= 1'b0;
			if (c_access)
				seen_access <= 1'b1;
			// a miss raises m_access three cycles after the request is sampled.
			err_pipe <= {err_pipe[1:0], fetch_start && c_addr[29:ob] == err_word[29:ob]};
			inval_pipe <= {inval_pipe[1:0], fetch_start && inval_seen && !ctrl_inval};
		end
		if (c_ack && !c_error)
			last_addr <= c_addr;
		exp_offs <= offs + 1'b1;
	end

	a_data: assert property (@(posedge clk) disable iff (rst)
		c_ack && !c_error |-> c_data == mem_word(c_addr))
		else begin
			fail_count++;
			$error("Error at %0t: c_data = %h, expected %h", $time, c_data, mem_word(c_addr));
		end

	// a hit acknowledges in the compare cycle and no fill follows it.
	a_repeat_hit: assert property (@(posedge clk) disable iff (rst)
		fetch_start && cached && c_addr == last_addr && !ctrl_inval
		|=> c_ack && !c_error ##1 !m_access [*2])
		else begin
			fail_count++;
			$error("repeated fetch of %h was not a one-cycle hit", last_addr);
		end

	a_line_held: assert property (@(posedge clk) disable iff (rst)
		m_access |-> m_addr[29:ob] == c_addr[29:ob])
		else begin
			fail_count++;
			$error("Error at %0t: m_addr = %h, expected line of %h", $time, m_addr, c_addr);
		end

	a_first_word: assert property (@(posedge clk) disable iff (rst)
		$rose(m_access) |-> offs == '0)
		else begin
			fail_count++;
			$error("fill did not start at word offset zero");
		end

	a_step: assert property (@(posedge clk) disable iff (rst)
		m_access && m_ack && offs != '1 |=> m_access && offs == exp_offs)
		else begin
			fail_count++;
			$error("fill offset did not advance by one after m_ack");
		end

	a_wait: assert property (@(posedge clk) disable iff (rst)
		m_access && !m_ack && !m_error |=> m_access && $stable(m_addr))
		else begin
			fail_count++;
			$error("memory request changed or dropped without an answer");
		end

	a_last: assert property (@(posedge clk) disable iff (rst)
		m_access && m_ack && offs == '1 |=> !m_access)
		else begin
			fail_count++;
			$error("m_access stayed high after the last word");
		end

	a_err_end: assert property (@(posedge clk) disable iff (rst)
		m_access && m_error |=> !m_access && c_ack && c_error)
		else begin
			fail_count++;
			$error("m_error did not end the fill with an error acknowledge");
		end

	a_err_refill: assert property (@(posedge clk) disable iff (rst)
		err_pipe[2] |-> m_access)
		else begin
			fail_count++;
			$error("fetch to the error line did not start a new fill");
		end

	a_inval_refill: assert property (@(posedge clk) disable iff (rst)
		inval_pipe[2] |-> m_access)
		else begin
			fail_count++;
			$error("first fetch after invalidate did not start a fill");
		end

	a_reset_quiet: assert property (@(posedge clk) disable iff (rst)
		!seen_access |-> !c_ack && !c_error && !m_access)
		else begin
			fail_count++;
			$error("outputs active after reset before any request");
		end

endmodule

bind icache_top tb_icache_sva #(.cache_bytes(cache_bytes), .line_bytes(line_bytes)) chk (
	.clk(clk),
	.rst(rst),
	.c_access(c_access),
	.c_addr(c_addr),
	.c_data(c_data),
	.c_ack(c_ack),
	.c_error(c_error),
	.ctrl_inval(ctrl_inval),
	.m_access(m_access),
	.m_addr(m_addr),
	.m_ack(m_ack),
	.m_error(m_error),
	.state(u_ctrl.state)
);

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none

module icache_top #(
	parameter int cache_bytes = cache_geom_pkg::default_cache_bytes,
	parameter int line_bytes = cache_geom_pkg::default_line_bytes
) (
	input wire clk,
	input wire rst,
	input wire c_access,
	input wire [cache_bus_pkg::addr_w-1:0] c_addr,
	output logic [cache_bus_pkg::data_w-1:0] c_data,
	output logic c_ack,
	output logic c_error,
	input wire ctrl_inval,
	output logic m_access,
	output logic [cache_bus_pkg::addr_w-1:0] m_addr,
	input wire [cache_bus_pkg::data_w-1:0] m_data,
	input wire m_ack,
	input wire m_error
);

	icache_array_if #(.cache_bytes(cache_bytes), .line_bytes(line_bytes)) arr ();

	icache_ctrl #(.cache_bytes(cache_bytes), .line_bytes(line_bytes)) u_ctrl (
		.clk(clk),
		.rst(rst),
		.c_access(c_access),
		.c_addr(c_addr),
		.c_data(c_data),
		.c_ack(c_ack),
		.c_error(c_error),
		.ctrl_inval(ctrl_inval),
		.m_access(m_access),
		.m_addr(m_addr),
		.m_data(m_data),
		.m_ack(m_ack),
		.m_error(m_error),
		.arr(arr.ctrl)
	);

	icache_tag_store #(.cache_bytes(cache_bytes), .line_bytes(line_bytes)) u_tags (
		.clk(clk),
		.rst(rst),
		.arr(arr.tags)
	);

	icache_data_store #(.cache_bytes(cache_bytes), .line_bytes(line_bytes)) u_data (
		.clk(clk),
		.arr(arr.data)
	);

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`default_nettype none

module icache_ctrl #(
	parameter int cache_bytes = cache_geom_pkg::default_cache_bytes,
	parameter int line_bytes = cache_geom_pkg::default_line_bytes
) (
	input wire clk,
	input wire rst,
	input wire c_access,
	input wire [cache_bus_pkg::addr_w-1:0] c_addr,
	output logic [cache_bus_pkg::data_w-1:0] c_data,
	output logic c_ack,
	output logic c_error,
	input wire ctrl_inval,
	output logic m_access,
	output logic [cache_bus_pkg::addr_w-1:0] m_addr,
	input wire [cache_bus_pkg::data_w-1:0] m_data,
	input wire m_ack,
	input wire m_error,
	icache_array_if.ctrl arr
);

	localparam int addr_w = cache_bus_pkg::addr_w;
	localparam int offset_w = cache_geom_pkg::offset_bits(line_bytes);
	localparam int index_w = cache_geom_pkg::index_bits(cache_bytes, line_bytes);
	localparam int tag_w = cache_geom_pkg::tag_bits(cache_bytes, line_bytes);

	cache_bus_pkg::ctrl_state_t state;
	cache_bus_pkg::ctrl_state_t next_state;

	logic [addr_w-1:0] lat_addr;
	logic [tag_w-1:0] lat_tag;
	logic [index_w-1:0] lat_index;
	logic [offset_w-1:0] word_offs;

	logic hit;
	logic req_new;
	logic fill_ack;
	logic fill_err;
	logic line_done;
	logic fill_done;

	assign lat_tag = lat_addr[addr_w-1 -: tag_w];
	assign lat_index = lat_addr[offset_w +: index_w];

	// lookups follow the live request so that held requests stream.
	assign arr.rd_index = c_addr[offset_w +: index_w];
	assign arr.rd_offset = c_addr[offset_w-1:0];
	assign arr.inval = ctrl_inval;

	// the memory only answers while a fill is on the bus.
	assign fill_ack = m_access && m_ack;
	assign fill_err = m_access && m_error;
	assign line_done = fill_ack && (&word_offs);

	assign arr.fill_we = fill_ack;
	assign arr.fill_index = lat_index;
	assign arr.fill_offset = word_offs;
	assign arr.fill_data = m_data;
	assign arr.tag_we = line_done;
	assign arr.tag_value = lat_tag;

	assign m_addr = {lat_addr[addr_w-1:offset_w], word_offs};

	assign hit = arr.rd_valid && (arr.rd_tag == lat_tag);
	assign c_ack = (state == cache_bus_pkg::state_compare && hit) || fill_done || c_error;
	assign c_data = arr.rd_data;

	// the request still held in its acknowledge cycle is not a new fetch.
	assign req_new = c_access && !(c_ack && c_addr == lat_addr);

	always_comb begin
		next_state = state;
		unique case (state)
		cache_bus_pkg::state_idle:
			if (req_new)
				next_state = cache_bus_pkg::state_compare;
		cache_bus_pkg::state_compare:
			if (!hit)
				next_state = cache_bus_pkg::state_fill;
			else if (!req_new)
				next_state = cache_bus_pkg::state_idle;
		cache_bus_pkg::state_fill:
			if (line_done || fill_err)
				next_state = cache_bus_pkg::state_idle;
		default:
			next_state = cache_bus_pkg::state_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= cache_bus_pkg::state_idle;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (req_new && state != cache_bus_pkg::state_fill)
			lat_addr <= c_addr; // held for the whole fill.
	end

	always_ff @(posedge clk) begin
		if (rst || state != cache_bus_pkg::state_fill)
			word_offs <= '0;
		else if (fill_ack)
			word_offs <= word_offs + 1'b1;
	end

	// m_access rises one cycle into the fill and drops with the last answer.
	always_ff @(posedge clk) begin
		if (rst) begin
			m_access <= 1'b0;
			fill_done <= 1'b0;
			c_error <= 1'b0;
		end else begin
			m_access <= state == cache_bus_pkg::state_fill && !line_done && !fill_err;
			fill_done <= line_done;
			c_error <= fill_err;
		end
	end

endmodule

`default_nettype wire

// ==== icache_data_store.sv ====
`default_nettype none

module icache_data_store #(
	parameter int cache_bytes = cache_geom_pkg::default_cache_bytes,
	parameter int line_bytes = cache_geom_pkg::default_line_bytes
) (
	input wire clk,
	icache_array_if.data arr
);

	localparam int offset_w = cache_geom_pkg::offset_bits(line_bytes);
	localparam int index_w = cache_geom_pkg::index_bits(cache_bytes, line_bytes);
	localparam int addr_bits = index_w + offset_w;
	localparam int words = 2 ** addr_bits;

	logic [cache_bus_pkg::data_w-1:0] mem [words];
	logic [addr_bits-1:0] wr_addr;
	logic [addr_bits-1:0] rd_addr;

	assign wr_addr = {arr.fill_index, arr.fill_offset};
	assign rd_addr = {arr.rd_index, arr.rd_offset};

	always_ff @(posedge clk) begin
		if (arr.fill_we)
			mem[wr_addr] <= arr.fill_data;
	end

	// the word asked for may be the one written on this same edge.
	always_ff @(posedge clk) begin
		if (arr.fill_we && wr_addr == rd_addr)
			arr.rd_data <= arr.fill_data;
		else
			arr.rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== icache_tag_store.sv ====
`default_nettype none

module icache_tag_store #(
	parameter int cache_bytes = cache_geom_pkg::default_cache_bytes,
	parameter int line_bytes = cache_geom_pkg::default_line_bytes
) (
	input wire clk,
	input wire rst,
	icache_array_if.tags arr
);

	localparam int index_w = cache_geom_pkg::index_bits(cache_bytes, line_bytes);
	localparam int tag_w = cache_geom_pkg::tag_bits(cache_bytes, line_bytes);
	localparam int lines = 2 ** index_w;

	logic [tag_w-1:0] tag_mem [lines];
	logic [lines-1:0] valid;

	always_ff @(posedge clk) begin
		if (arr.tag_we)
			tag_mem[arr.fill_index] <= arr.tag_value;
	end

	// clearing wins over the set of a completing fill.
	always_ff @(posedge clk) begin
		if (rst || arr.inval)
			valid <= '0;
		else if (arr.tag_we)
			valid[arr.fill_index] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		arr.rd_tag <= tag_mem[arr.rd_index];
	end

	// an invalidate on the lookup edge must not let the old valid bit through.
	always_ff @(posedge clk) begin
		if (rst || arr.inval)
			arr.rd_valid <= 1'b0;
		else
			arr.rd_valid <= valid[arr.rd_index];
	end

endmodule

`default_nettype wire

// ==== icache_array_if.sv ====
`default_nettype none

interface icache_array_if #(
	parameter int cache_bytes = cache_geom_pkg::default_cache_bytes,
	parameter int line_bytes = cache_geom_pkg::default_line_bytes
);

	localparam int offset_w = cache_geom_pkg::offset_bits(line_bytes);
	localparam int index_w = cache_geom_pkg::index_bits(cache_bytes, line_bytes);
	localparam int tag_w = cache_geom_pkg::tag_bits(cache_bytes, line_bytes);

	// lookup results come back one cycle after the position is presented.
	logic [index_w-1:0] rd_index;
	logic [offset_w-1:0] rd_offset;
	logic [tag_w-1:0] rd_tag;
	logic rd_valid;
	logic [cache_bus_pkg::data_w-1:0] rd_data;

	logic fill_we;
	logic [index_w-1:0] fill_index; // also the line whose tag is written.
	logic [offset_w-1:0] fill_offset;
	logic [cache_bus_pkg::data_w-1:0] fill_data;

	logic tag_we;
	logic [tag_w-1:0] tag_value;
	logic inval;

	modport ctrl (
		output rd_index, rd_offset, fill_we, fill_index, fill_offset, fill_data,
		output tag_we, tag_value, inval,
		input rd_tag, rd_valid, rd_data
	);

	modport tags (
		input rd_index, fill_index, tag_we, tag_value, inval,
		output rd_tag, rd_valid
	);

	modport data (
		input rd_index, rd_offset, fill_we, fill_index, fill_offset, fill_data,
		output rd_data
	);

endinterface

`default_nettype wire

// ==== cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

	localparam int default_cache_bytes = 8192;
	localparam int default_line_bytes = 32;

	// the word select within a line is the lowest field of the word address.
	function automatic int offset_bits(int line_bytes);
		int line_words;
		line_words = line_bytes / (cache_bus_pkg::data_w / 8);
		return $clog2(line_words);
	endfunction

	function automatic int index_bits(int cache_bytes, int line_bytes);
		return $clog2(cache_bytes / line_bytes); // one index per line.
	endfunction

	// whatever the offset and index leave of the address.
	function automatic int tag_bits(int cache_bytes, int line_bytes);
		int used;
		used = offset_bits(line_bytes) + index_bits(cache_bytes, line_bytes);
		return cache_bus_pkg::addr_w - used;
	endfunction

endpackage

`default_nettype wire

// ==== cache_bus_pkg.sv ====
`default_nettype none

package cache_bus_pkg;

	// the fetch and memory buses both carry word addresses.
	localparam int addr_w = 30;
	localparam int data_w = 32;

	// one-hot controller states.
	typedef enum logic [2:0] {
		state_idle    = 3'b001,
		state_compare = 3'b010,
		state_fill    = 3'b100
	} ctrl_state_t;

endpackage

`default_nettype wire
